/* rtl/uart_pkg.sv */
/*
 * Shared definitions for the UART peripheral: register map,
 * status bit positions and serial data width.
 */

`default_nettype none

package uart_pkg;

    ////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////

    // host register addresses
    typedef enum logic [1:0] {
        // baud divisor, read and write
        reg_bdr = 2'd0,
        // transmit data, write only
        reg_txd = 2'd1,
        // receive data, read pops the receive FIFO
        reg_rxd = 2'd2,
        // status, read clears the overflow flag
        reg_sts = 2'd3
    } uart_reg_e;

    ////////////////////////////////////////////////////////////
    // data and status
    ////////////////////////////////////////////////////////////

    // serial payload width
    localparam int unsigned dat_width = 8;

    // status register bit positions
    localparam int unsigned sts_tx_full  = 0;
    localparam int unsigned sts_tx_empty = 1;
    localparam int unsigned sts_rx_empty = 2;
    localparam int unsigned sts_rx_ovf   = 3;

endpackage

`default_nettype wire

/* rtl/uart_fifo.sv */
/*
 * Show-ahead synchronous FIFO, head entry visible without a pop.
 * Depth must be a power of two. Used for transmit and receive.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
    parameter int unsigned width = 8,
    parameter int unsigned depth = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic [width-1:0] wdt,
    input  logic             pop,
    output logic [width-1:0] head,
    output logic             full,
    output logic             empty
);

    localparam int unsigned adr_width = $clog2(depth);

    // storage
    logic [width-1:0]   mem [depth];
    // extra msb tells full from empty
    logic [adr_width:0] wr_ptr;
    logic [adr_width:0] rd_ptr;

    ////////////////////////////////////////////////////////////
    // pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // same index, different lap
    assign full  = (wr_ptr ^ rd_ptr) == {1'b1, {adr_width{1'b0}}};
    assign empty = wr_ptr == rd_ptr;

    ////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr[adr_width-1:0]] <= wdt;
    end

    assign head = mem[rd_ptr[adr_width-1:0]];

endmodule

`default_nettype wire

/* rtl/uart_ser.sv */
/*
 * Serializer: takes bytes from a valid/ready stream and sends
 * them on txd as start bit, data LSB first, then stop bits.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_ser #(
    parameter int unsigned bdr_width = 16,
    parameter int unsigned stp_width = 1
) (
    input  logic                           clk,
    input  logic                           rst,
    // bit period minus one
    input  logic [bdr_width-1:0]           cfg_bdr,
    // byte stream from the transmit FIFO
    input  logic                           str_vld,
    input  logic [uart_pkg::dat_width-1:0] str_dat,
    output logic                           str_rdy,
    // serial line
    output logic                           txd
);

    // frame length in bits
    localparam int unsigned shf_len   = 1 + uart_pkg::dat_width + stp_width;
    localparam int unsigned cnt_width = $clog2(shf_len);

    logic                           str_trn;
    logic [bdr_width-1:0]           bdr_cnt;
    logic                           bdr_end;
    logic [cnt_width-1:0]           shf_cnt;
    logic                           shf_end;
    logic                           shf_run;
    // start bit plus data
    logic [uart_pkg::dat_width:0]   shf_dat;

    ////////////////////////////////////////////////////////////
    // stream handshake
    ////////////////////////////////////////////////////////////

    assign str_trn = str_vld & str_rdy;
    // ready again in the last stop bit cycle, no idle gap
    assign str_rdy = ~shf_run | (shf_end & bdr_end);

    ////////////////////////////////////////////////////////////
    // baud and bit counters
    ////////////////////////////////////////////////////////////

    assign bdr_end = bdr_cnt == cfg_bdr;
    assign shf_end = shf_cnt == cnt_width'(shf_len - 1);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            bdr_cnt <= '0;
            shf_cnt <= '0;
            shf_run <= 1'b0;
        end else if (str_trn) begin
            // restart on each new frame
            bdr_cnt <= '0;
            shf_cnt <= '0;
            shf_run <= 1'b1;
        end else if (shf_run) begin
            bdr_cnt <= bdr_end ? '0 : bdr_cnt + 1'b1;
            if (bdr_end) begin
                shf_cnt <= shf_end ? '0 : shf_cnt + 1'b1;
                shf_run <= ~shf_end;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // shift register
    ////////////////////////////////////////////////////////////

    // ones shifted in make the stop bits and idle level
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            shf_dat <= '1;
        end else if (str_trn) begin
            shf_dat <= {str_dat, 1'b0};
        end else if (shf_run && bdr_end) begin
            shf_dat <= {1'b1, shf_dat[uart_pkg::dat_width:1]};
        end
    end

    assign txd = shf_dat[0];

endmodule

`default_nettype wire

/* rtl/uart_des.sv */
/*
 * Deserializer: finds start bits on rxd, samples each bit in its
 * middle and pulses rx_vld with the byte when the stop bit is high.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_des #(
    parameter int unsigned bdr_width = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    // bit period minus one
    input  logic [bdr_width-1:0]           cfg_bdr,
    // asynchronous serial input
    input  logic                           rxd,
    // received byte, one cycle pulse
    output logic                           rx_vld,
    output logic [uart_pkg::dat_width-1:0] rx_dat
);

    localparam int unsigned cnt_width = $clog2(uart_pkg::dat_width);

    typedef enum logic [1:0] {idle, start, data, stop} des_state_e;

    des_state_e           state;
    // two sync flops plus one for edge detect
    logic [2:0]           rxd_sync;
    logic                 rxd_s;
    logic                 rxd_fall;
    logic [bdr_width-1:0] bdr_cnt;
    logic                 half_end;
    logic                 bit_end;
    logic [cnt_width-1:0] bit_cnt;

    ////////////////////////////////////////////////////////////
    // input synchronizer
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rxd_sync <= '1;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
        end
    end

    assign rxd_s    = rxd_sync[1];
    assign rxd_fall = rxd_sync[2] & ~rxd_sync[1];

    // half period finds mid start bit, full period steps bits
    assign half_end = bdr_cnt == (cfg_bdr >> 1);
    assign bit_end  = bdr_cnt == cfg_bdr;

    ////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state   <= idle;
            bdr_cnt <= '0;
            bit_cnt <= '0;
            rx_vld  <= 1'b0;
        end else begin
            rx_vld <= 1'b0;
            case (state)
                idle: begin
                    bdr_cnt <= '0;
                    if (rxd_fall) state <= start;
                end
                start: begin
                    if (half_end) begin
                        // glitch, line went back high
                        state   <= rxd_s ? idle : data;
                        bdr_cnt <= '0;
                        bit_cnt <= '0;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                data: begin
                    if (bit_end) begin
                        bdr_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_width'(uart_pkg::dat_width - 1)) state <= stop;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                stop: begin
                    if (bit_end) begin
                        // low stop bit drops the frame
                        rx_vld  <= rxd_s;
                        bdr_cnt <= '0;
                        state   <= idle;
                    end else begin
                        bdr_cnt <= bdr_cnt + 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // data bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == data && bit_end) begin
            rx_dat <= {rxd_s, rx_dat[uart_pkg::dat_width-1:1]};
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_ctl.sv */
/*
 * Register block: decodes host strobes, holds the baud divisor and
 * the sticky receive overflow flag, and gates FIFO push and pop.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_ctl #(
    parameter int unsigned bdr_width = 16
) (
    input  logic                           clk,
    input  logic                           rst,
    // host bus
    input  logic                           req,
    input  logic                           wen,
    input  logic [1:0]                     adr,
    input  logic [bdr_width-1:0]           wdt,
    output logic [bdr_width-1:0]           rdt,
    // baud divisor to ser and des
    output logic [bdr_width-1:0]           cfg_bdr,
    // transmit FIFO
    output logic                           tx_push,
    output logic [uart_pkg::dat_width-1:0] tx_dat,
    input  logic                           tx_full,
    input  logic                           tx_empty,
    // deserializer output
    input  logic                           rx_vld,
    input  logic [uart_pkg::dat_width-1:0] rx_dat,
    // receive FIFO
    output logic                           rx_push,
    output logic [uart_pkg::dat_width-1:0] rx_wdt,
    output logic                           rx_pop,
    input  logic [uart_pkg::dat_width-1:0] rx_head,
    input  logic                           rx_full,
    input  logic                           rx_empty
);

    uart_pkg::uart_reg_e  reg_sel;
    logic                 wr_req;
    logic                 rd_req;
    logic                 rx_ovf;
    logic [bdr_width-1:0] rd_val;

    assign reg_sel = uart_pkg::uart_reg_e'(adr);
    assign wr_req  = req & wen;
    assign rd_req  = req & ~wen;

    ////////////////////////////////////////////////////////////
    // baud divisor
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg_bdr <= '0;
        end else if (wr_req && reg_sel == uart_pkg::reg_bdr) begin
            cfg_bdr <= wdt;
        end
    end

    ////////////////////////////////////////////////////////////
    // FIFO steering
    ////////////////////////////////////////////////////////////

    // write to a full transmit FIFO is dropped
    assign tx_push = wr_req & (reg_sel == uart_pkg::reg_txd) & ~tx_full;
    assign tx_dat  = wdt[uart_pkg::dat_width-1:0];

    // no back-pressure on receive
    assign rx_push = rx_vld & ~rx_full;
    assign rx_wdt  = rx_dat;
    assign rx_pop  = rd_req & (reg_sel == uart_pkg::reg_rxd) & ~rx_empty;

    // sticky overflow, a new loss wins over the clear
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rx_ovf <= 1'b0;
        end else if (rx_vld && rx_full) begin
            rx_ovf <= 1'b1;
        end else if (rd_req && reg_sel == uart_pkg::reg_sts) begin
            rx_ovf <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // read data
    ////////////////////////////////////////////////////////////

    always_comb begin
        rd_val = '0;
        case (reg_sel)
            uart_pkg::reg_bdr: rd_val = cfg_bdr;
            uart_pkg::reg_rxd: begin
                // empty FIFO reads as zero
                if (!rx_empty) rd_val[uart_pkg::dat_width-1:0] = rx_head;
            end
            uart_pkg::reg_sts: begin
                rd_val[uart_pkg::sts_tx_full]  = tx_full;
                rd_val[uart_pkg::sts_tx_empty] = tx_empty;
                rd_val[uart_pkg::sts_rx_empty] = rx_empty;
                rd_val[uart_pkg::sts_rx_ovf]   = rx_ovf;
            end
            // transmit data is write only
            default: rd_val = '0;
        endcase
    end

    // one cycle latency, held until the next read
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rdt <= '0;
        end else if (rd_req) begin
            rdt <= rd_val;
        end
    end

endmodule

`default_nettype wire

/* rtl/uart_top.sv */
/*
 * UART peripheral top level: register block, transmit and receive
 * FIFOs, serializer and deserializer. Instances and wiring only.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_top #(
    parameter int unsigned bdr_width  = 16,
    parameter int unsigned stp_width  = 1,
    parameter int unsigned fifo_depth = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    // host bus
    input  logic                 req,
    input  logic                 wen,
    input  logic [1:0]           adr,
    input  logic [bdr_width-1:0] wdt,
    output logic [bdr_width-1:0] rdt,
    // serial lines
    output logic                 txd,
    input  logic                 rxd
);

    logic [bdr_width-1:0]           cfg_bdr;
    // transmit side
    logic                           tx_push;
    logic [uart_pkg::dat_width-1:0] tx_dat;
    logic                           tx_full;
    logic                           tx_empty;
    logic                           str_vld;
    logic [uart_pkg::dat_width-1:0] str_dat;
    logic                           str_rdy;
    // receive side
    logic                           rx_vld;
    logic [uart_pkg::dat_width-1:0] rx_dat;
    logic                           rx_push;
    logic [uart_pkg::dat_width-1:0] rx_wdt;
    logic                           rx_pop;
    logic [uart_pkg::dat_width-1:0] rx_head;
    logic                           rx_full;
    logic                           rx_empty;

    // stream valid is simply a non-empty FIFO
    assign str_vld = ~tx_empty;

    uart_ctl #(
        .bdr_width (bdr_width)
    ) ctl (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .wen      (wen),
        .adr      (adr),
        .wdt      (wdt),
        .rdt      (rdt),
        .cfg_bdr  (cfg_bdr),
        .tx_push  (tx_push),
        .tx_dat   (tx_dat),
        .tx_full  (tx_full),
        .tx_empty (tx_empty),
        .rx_vld   (rx_vld),
        .rx_dat   (rx_dat),
        .rx_push  (rx_push),
        .rx_wdt   (rx_wdt),
        .rx_pop   (rx_pop),
        .rx_head  (rx_head),
        .rx_full  (rx_full),
        .rx_empty (rx_empty)
    );

    ////////////////////////////////////////////////////////////
    // transmit path
    ////////////////////////////////////////////////////////////

    // popped by the stream transfer
    uart_fifo #(
        .width (uart_pkg::dat_width),
        .depth (fifo_depth)
    ) tx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (tx_push),
        .wdt   (tx_dat),
        .pop   (str_vld & str_rdy),
        .head  (str_dat),
        .full  (tx_full),
        .empty (tx_empty)
    );

    uart_ser #(
        .bdr_width (bdr_width),
        .stp_width (stp_width)
    ) ser (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (cfg_bdr),
        .str_vld (str_vld),
        .str_dat (str_dat),
        .str_rdy (str_rdy),
        .txd     (txd)
    );

    ////////////////////////////////////////////////////////////
    // receive path
    ////////////////////////////////////////////////////////////

    uart_des #(
        .bdr_width (bdr_width)
    ) des (
        .clk     (clk),
        .rst     (rst),
        .cfg_bdr (cfg_bdr),
        .rxd     (rxd),
        .rx_vld  (rx_vld),
        .rx_dat  (rx_dat)
    );

    uart_fifo #(
        .width (uart_pkg::dat_width),
        .depth (fifo_depth)
    ) rx_fifo (
        .clk   (clk),
        .rst   (rst),
        .push  (rx_push),
        .wdt   (rx_wdt),
        .pop   (rx_pop),
        .head  (rx_head),
        .full  (rx_full),
        .empty (rx_empty)
    );

endmodule

`default_nettype wire

/* testbench/uart_tb.sv */
/*
 * Loopback testbench for the UART peripheral. txd is tied to rxd,
 * bytes go out through the transmit register and come back through
 * the receive register, checked against a reference byte queue.
 */

`timescale 1ns/1ps
`default_nettype none

module uart_tb;

    localparam int bdr_width  = 16;
    localparam int stp_width  = 1;
    localparam int fifo_depth = 4;
    // bits per frame for start, data and stop
    localparam int frame_bits = 1 + uart_pkg::dat_width + stp_width;
    // largest divisor used by the tests
    localparam int max_bdr    = 20;
    localparam int frames_all = 16;
    localparam int wd_cycles  = 16 + frames_all * frame_bits * (max_bdr + 1) * 4;
    localparam int poll_limit = frame_bits * 32;

    logic                 clk;
    logic                 rst;
    logic                 req;
    logic                 wen;
    logic [1:0]           adr;
    logic [bdr_width-1:0] wdt;
    logic [bdr_width-1:0] rdt;
    // serial loopback wire
    wire                  serial;

    integer               seed;
    int                   cur_bdr;
    // reference model queues of bytes sent and bytes read back
    logic [7:0]           exp_q[$];
    logic [7:0]           rcv_q[$];
    event                 byte_rcvd;

    uart_top #(
        .bdr_width  (bdr_width),
        .stp_width  (stp_width),
        .fifo_depth (fifo_depth)
    ) UUT (
        .clk (clk),
        .rst (rst),
        .req (req),
        .wen (wen),
        .adr (adr),
        .wdt (wdt),
        .rdt (rdt),
        .txd (serial),
        .rxd (serial)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reporting
    ////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %0t: %s: got 0x%0h, expected 0x%0h", $time, what, act, exp);
            stop_run("value mismatch, run stopped");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////

    // status bits from FIFO occupancy and the overflow flag
    function automatic logic [bdr_width-1:0] sts_predict(input int tx_cnt, input int rx_cnt,
                                                          input bit ovf);
        logic [bdr_width-1:0] s;
        s = '0;
        s[uart_pkg::sts_tx_full]  = (tx_cnt == fifo_depth);
        s[uart_pkg::sts_tx_empty] = (tx_cnt == 0);
        s[uart_pkg::sts_rx_empty] = (rx_cnt == 0);
        s[uart_pkg::sts_rx_ovf]   = ovf;
        return s;
    endfunction

    // compares every received byte with the queue head
    initial begin
        forever begin
            @(byte_rcvd);
            while (rcv_q.size() > 0) begin
                if (exp_q.size() == 0) begin
                    stop_run("a byte was received that was never sent");
                end else begin
                    check("loopback byte", rcv_q.pop_front(), exp_q.pop_front());
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // host bus
    ////////////////////////////////////////////////////////////

    task automatic bus_write(input logic [1:0] a, input logic [bdr_width-1:0] d);
        @(posedge clk);
        #2;
        req = 1'b1;
        wen = 1'b1;
        adr = a;
        wdt = d;
        @(posedge clk);
        #2;
        req = 1'b0;
        wen = 1'b0;
    endtask

    // rdt is registered and valid one cycle after req
    task automatic bus_read(input logic [1:0] a, output logic [bdr_width-1:0] d);
        @(posedge clk);
        #2;
        req = 1'b1;
        wen = 1'b0;
        adr = a;
        @(posedge clk);
        #2;
        req = 1'b0;
        d   = rdt;
    endtask

    task automatic set_bdr(input int v);
        bus_write(uart_pkg::reg_bdr, bdr_width'(v));
        cur_bdr = v;
    endtask

    // n bit periods at the current divisor
    task automatic wait_bits(input int n);
        repeat (n * (cur_bdr + 1)) @(posedge clk);
    endtask

    task automatic wait_sts_clear(input int bit_pos, input string what);
        logic [bdr_width-1:0] v;
        int                   tries;
        tries = 0;
        bus_read(uart_pkg::reg_sts, v);
        while (v[bit_pos]) begin
            tries++;
            if (tries > poll_limit) stop_run({"timed out waiting for ", what});
            bus_read(uart_pkg::reg_sts, v);
        end
    endtask

    // poll until rx not empty, then pop one byte
    task automatic receive_byte();
        logic [bdr_width-1:0] v;
        wait_sts_clear(uart_pkg::sts_rx_empty, "a received byte");
        bus_read(uart_pkg::reg_rxd, v);
        check("rxd upper bits", v[bdr_width-1:8], 0);
        rcv_q.push_back(v[7:0]);
        ->byte_rcvd;
    endtask

    ////////////////////////////////////////////////////////////
    // watchdog
    ////////////////////////////////////////////////////////////

    initial begin
        repeat (wd_cycles) @(posedge clk);
        stop_run("watchdog expired, the tests took far longer than their frames need");
    end

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        logic [bdr_width-1:0] v;
        logic [7:0]           b;
        int                   dropped;
        int                   low_cnt;
        int                   bdr_list[3];
        seed     = 11;
        cur_bdr  = 0;
        bdr_list = '{3, 6, 10};
        rst      = 1'b1;
        req      = 1'b0;
        wen      = 1'b0;
        adr      = '0;
        wdt      = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // reset state
        bus_read(uart_pkg::reg_sts, v);
        check("status after reset", v, sts_predict(0, 0, 1'b0));
        bus_read(uart_pkg::reg_bdr, v);
        check("divisor after reset", v, 0);
        check("txd idle", serial, 1);

        // register access
        bus_write(uart_pkg::reg_bdr, 16'ha5c3);
        bus_read(uart_pkg::reg_bdr, v);
        check("divisor readback", v, 16'ha5c3);
        bus_read(uart_pkg::reg_txd, v);
        check("txd read", v, 0);

        // single bytes at growing divisors
        foreach (bdr_list[i]) begin
            set_bdr(bdr_list[i]);
            b = 8'($random(seed));
            exp_q.push_back(b);
            bus_write(uart_pkg::reg_txd, {8'h00, b});
            receive_byte();
            wait_bits(2);
        end

        // burst of one frame in flight plus a full FIFO and one lost write
        set_bdr(15);
        dropped = 0;
        for (int i = 0; i < fifo_depth + 2; i++) begin
            bus_read(uart_pkg::reg_sts, v);
            b = 8'($random(seed));
            bus_write(uart_pkg::reg_txd, {8'h00, b});
            if (v[uart_pkg::sts_tx_full]) dropped++;
            else exp_q.push_back(b);
        end
        check("dropped writes", dropped, 1);
        repeat (fifo_depth + 1) receive_byte();
        wait_bits(2);

        // overflow with no reads until the transmit side drains
        for (int i = 0; i < fifo_depth + 1; i++) begin
            b = 8'($random(seed));
            bus_write(uart_pkg::reg_txd, {8'h00, b});
            if (i < fifo_depth) exp_q.push_back(b);
        end
        bus_read(uart_pkg::reg_sts, v);
        check("status tx full", v, sts_predict(fifo_depth, 0, 1'b0));
        wait_sts_clear(uart_pkg::sts_tx_full, "transmit FIFO space");
        bus_read(uart_pkg::reg_sts, v);
        while (!v[uart_pkg::sts_tx_empty]) bus_read(uart_pkg::reg_sts, v);
        // last frame still on the wire
        wait_bits(frame_bits + 1);
        bus_read(uart_pkg::reg_sts, v);
        check("status overflow", v, sts_predict(0, fifo_depth, 1'b1));
        bus_read(uart_pkg::reg_sts, v);
        check("status overflow cleared", v, sts_predict(0, fifo_depth, 1'b0));
        repeat (fifo_depth) receive_byte();
        bus_read(uart_pkg::reg_sts, v);
        check("status drained", v, sts_predict(0, 0, 1'b0));

        // start bit width with lsb set so only the start bit is low
        set_bdr(max_bdr);
        exp_q.push_back(8'ha5);
        bus_write(uart_pkg::reg_txd, 16'h00a5);
        low_cnt = 0;
        while (serial !== 1'b0) begin
            low_cnt++;
            if (low_cnt > max_bdr * 4) stop_run("start bit never appeared on txd");
            @(posedge clk);
            #1;
        end
        low_cnt = 0;
        while (serial === 1'b0) begin
            low_cnt++;
            @(posedge clk);
            #1;
        end
        check("start bit cycles", low_cnt, max_bdr + 1);
        receive_byte();

        // let the compare process take the last byte
        @(posedge clk);
        check("bytes never received", exp_q.size(), 0);
        check("bytes never compared", rcv_q.size(), 0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* uart_top.f */
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_ser.sv
rtl/uart_des.sv
rtl/uart_ctl.sv
rtl/uart_top.sv
testbench/uart_tb.sv

/* Makefile */
# Verilator build and run for the UART peripheral testbench

VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= uart_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only if the pass message shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
